/* compile.f */
rtl/mmcm_drp_pkg.sv
rtl/mmcm_cfg_pkg.sv
rtl/mmcm_loop_table.sv
rtl/mmcm_reg_image.sv
rtl/mmcm_drp_rmw.sv
rtl/mmcm_reconfig_top.sv
sim/mmcm_drp_model.sv
sim/tb_mmcm_reconfig.sv

/* rtl/mmcm_cfg_pkg.sv */
package mmcm_cfg_pkg;

   localparam int MAX_CLKOUT = 7;

   typedef logic [4:0] step_t;

   // One output or feedback counter
   typedef struct packed {
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic [2:0] phase_mux;
      logic       edge_bit;
      logic       no_count;
      logic [5:0] delay_time;
   } cnt_cfg_t;

   // Input divider, no phase
   typedef struct packed {
      logic [5:0] high_time;
      logic [5:0] low_time;
      logic       edge_bit;
      logic       no_count;
   } div_cfg_t;

   // Lock detector setting, 40 bits
   typedef struct packed {
      logic [4:0] ref_dly;     // 39:35
      logic [4:0] fb_dly;      // 34:30
      logic [9:0] lock_cnt;    // 29:20
      logic [9:0] sat_high;    // 19:10
      logic [9:0] unlock_cnt;  // 9:0
   } lock_cfg_t;

   // Loop filter setting
   typedef logic [9:0] filt_cfg_t;

endpackage

/* rtl/mmcm_drp_pkg.sv */
package mmcm_drp_pkg;

   typedef logic [6:0]  drp_addr_t;
   typedef logic [15:0] drp_data_t;

   // Toward the MMCM
   typedef struct packed {
      drp_addr_t addr;
      drp_data_t wdata;
      logic      en;
      logic      we;
   } drp_req_t;

   typedef struct packed {
      drp_data_t rdata;
      logic      rdy;
   } drp_rsp_t;

   localparam drp_addr_t POWER_REG     = 7'h28;
   localparam drp_addr_t CLKFBOUT_REG1 = 7'h14;
   localparam drp_addr_t CLKFBOUT_REG2 = 7'h15;
   localparam drp_addr_t DIVCLK_REG    = 7'h16;
   localparam drp_addr_t LOCK_REG1     = 7'h18;
   localparam drp_addr_t LOCK_REG2     = 7'h19;
   localparam drp_addr_t LOCK_REG3     = 7'h1A;
   localparam drp_addr_t FILT_REG1     = 7'h4E;
   localparam drp_addr_t FILT_REG2     = 7'h4F;

   // CLKOUT0..6 first register, second one at +1
   localparam drp_addr_t [0:6] CLKOUT_REG1_ADDR =
      {7'h08, 7'h0A, 7'h0C, 7'h0E, 7'h10, 7'h06, 7'h12};

   // Set bits are kept from the read value
   localparam drp_data_t MASK_POWER      = 16'h0000;
   localparam drp_data_t MASK_CNT_REG1   = 16'h1000;
   localparam drp_data_t MASK_CLK0_REG2  = 16'h8000;  // CLKOUT0 and CLKFBOUT
   localparam drp_data_t MASK_CNT_REG2   = 16'hFC00;  // CLKOUT1..4
   localparam drp_data_t MASK_CLK56_REG2 = 16'hC000;
   localparam drp_data_t MASK_DIVCLK     = 16'hC000;
   localparam drp_data_t MASK_LOCK1      = 16'hFC00;
   localparam drp_data_t MASK_LOCK23     = 16'h8000;
   localparam drp_data_t MASK_FILT1      = 16'h66FF;
   localparam drp_data_t MASK_FILT2      = 16'h666F;

   typedef enum logic [3:0] {
      restart,
      wait_lock,
      wait_start,
      address,
      wait_a_rdy,
      bitmask,
      bitset,
      write,
      wait_rdy
   } rmw_state_t;

endpackage

/* rtl/mmcm_drp_rmw.sv */
`timescale 1ns/10ps

module mmcm_drp_rmw #(
   parameter int num_clkout = 7
) (
   input  logic                    dclk,
   input  logic                    rst,
   input  logic                    start,
   input  logic                    locked,
   output mmcm_cfg_pkg::step_t     step,
   input  mmcm_drp_pkg::drp_addr_t addr,
   input  mmcm_drp_pkg::drp_data_t mask,
   input  mmcm_drp_pkg::drp_data_t data,
   output mmcm_drp_pkg::drp_req_t  req,
   input  mmcm_drp_pkg::drp_rsp_t  rsp,
   output logic                    rst_mmcm,
   output logic                    ready,
   output logic                    done
);

   localparam mmcm_cfg_pkg::step_t num_steps = mmcm_cfg_pkg::step_t'(2 * num_clkout + 9);

   mmcm_drp_pkg::rmw_state_t state;
   mmcm_cfg_pkg::step_t      remaining;  // Writes left in this run

   always_ff @(posedge dclk) begin
      req.en <= 1'b0;  // en, we and done are single pulses
      req.we <= 1'b0;
      done   <= 1'b0;
      if (rst) begin
         state     <= mmcm_drp_pkg::restart;
         step      <= '0;
         remaining <= num_steps;
         rst_mmcm  <= 1'b1;
         ready     <= 1'b0;
      end else begin
         case (state)
            mmcm_drp_pkg::restart: begin
               rst_mmcm <= 1'b1;
               state    <= mmcm_drp_pkg::wait_lock;
            end

            mmcm_drp_pkg::wait_lock: begin
               rst_mmcm  <= 1'b0;
               step      <= '0;
               remaining <= num_steps;
               if (locked) begin
                  ready <= 1'b1;
                  state <= mmcm_drp_pkg::wait_start;
               end
            end

            mmcm_drp_pkg::wait_start: begin
               if (start) begin
                  ready    <= 1'b0;
                  rst_mmcm <= 1'b1;  // Held until the run is over
                  req.addr <= addr;
                  req.en   <= 1'b1;
                  state    <= mmcm_drp_pkg::address;
               end
            end

            // Read pulse on the bus
            mmcm_drp_pkg::address: state <= mmcm_drp_pkg::wait_a_rdy;

            mmcm_drp_pkg::wait_a_rdy: begin
               if (rsp.rdy) begin
                  req.wdata <= rsp.rdata;  // rdata only valid with rdy
                  state     <= mmcm_drp_pkg::bitmask;
               end
            end

            mmcm_drp_pkg::bitmask: begin
               req.wdata <= req.wdata & mask;
               state     <= mmcm_drp_pkg::bitset;
            end

            mmcm_drp_pkg::bitset: begin
               req.wdata <= req.wdata | data;
               req.en    <= 1'b1;
               req.we    <= 1'b1;
               state     <= mmcm_drp_pkg::write;
            end

            // Write pulse on the bus, advance so the next address is ready
            mmcm_drp_pkg::write: begin
               remaining <= remaining - 1'b1;
               if (remaining != 5'd1)
                  step <= step + 1'b1;
               state <= mmcm_drp_pkg::wait_rdy;
            end

            mmcm_drp_pkg::wait_rdy: begin
               if (rsp.rdy) begin
                  if (remaining == '0) begin
                     done  <= 1'b1;
                     state <= mmcm_drp_pkg::wait_lock;  // Releases rst_mmcm next
                  end else begin
                     req.addr <= addr;
                     req.en   <= 1'b1;
                     state    <= mmcm_drp_pkg::address;
                  end
               end
            end

            default: state <= mmcm_drp_pkg::restart;
         endcase
      end
   end

   we_with_en: assert property (@(posedge dclk) disable iff (rst)
      req.we |-> req.en);

   // One transfer in flight, MMCM answers each en with one rdy
   single_outstanding: assert property (@(posedge dclk) disable iff (rst)
      req.en |=> !req.en until_with rsp.rdy);

endmodule

/* rtl/mmcm_loop_table.sv */
`timescale 1ns/10ps

module mmcm_loop_table (
   input  logic                    dclk,
   input  mmcm_cfg_pkg::div_cfg_t  div,
   output mmcm_cfg_pkg::lock_cfg_t lock,
   output mmcm_cfg_pkg::filt_cfg_t filt
);

   logic [7:0]              div_idx;
   logic [4:0]              lock_dly;
   logic [9:0]              lock_cnt;
   mmcm_cfg_pkg::filt_cfg_t filt_nxt;

   // Divide value minus one, bypassed counter counts as divide by one
   assign div_idx = div.no_count ? 8'd0 :
                    8'(div.high_time) + 8'(div.low_time) - 8'd1;

   // Bandwidth "optimized" tables
   always_comb begin
      case (div_idx) inside
         [8'd0:8'd1]:   lock_dly = 5'd6;
         8'd2:          lock_dly = 5'd8;
         8'd3:          lock_dly = 5'd11;
         8'd4:          lock_dly = 5'd14;
         8'd5:          lock_dly = 5'd17;
         8'd6:          lock_dly = 5'd19;
         8'd7:          lock_dly = 5'd22;
         8'd8:          lock_dly = 5'd25;
         8'd9:          lock_dly = 5'd28;
         [8'd10:8'd63]: lock_dly = 5'd31;
         default:       lock_dly = 5'd6;
      endcase

      case (div_idx) inside
         [8'd0:8'd9]:   lock_cnt = 10'd1000;
         8'd10:         lock_cnt = 10'd900;
         8'd11:         lock_cnt = 10'd825;
         8'd12:         lock_cnt = 10'd750;
         8'd13:         lock_cnt = 10'd700;
         8'd14:         lock_cnt = 10'd650;
         8'd15:         lock_cnt = 10'd625;
         8'd16:         lock_cnt = 10'd575;
         8'd17:         lock_cnt = 10'd550;
         8'd18:         lock_cnt = 10'd525;
         8'd19:         lock_cnt = 10'd500;
         8'd20:         lock_cnt = 10'd475;
         8'd21:         lock_cnt = 10'd450;
         8'd22:         lock_cnt = 10'd425;
         [8'd23:8'd24]: lock_cnt = 10'd400;
         8'd25:         lock_cnt = 10'd375;
         [8'd26:8'd27]: lock_cnt = 10'd350;
         [8'd28:8'd29]: lock_cnt = 10'd325;
         [8'd30:8'd32]: lock_cnt = 10'd300;
         [8'd33:8'd35]: lock_cnt = 10'd275;
         [8'd36:8'd63]: lock_cnt = 10'd250;
         default:       lock_cnt = 10'd1000;
      endcase

      case (div_idx) inside
         8'd0:          filt_nxt = 10'b0010_1111_00;
         8'd1:          filt_nxt = 10'b0100_1111_00;
         8'd2:          filt_nxt = 10'b0101_1011_00;
         8'd3:          filt_nxt = 10'b0111_0111_00;
         8'd4:          filt_nxt = 10'b1101_0111_00;
         8'd5:          filt_nxt = 10'b1110_1011_00;
         8'd6:          filt_nxt = 10'b1110_1101_00;
         8'd7:          filt_nxt = 10'b1111_0011_00;
         8'd8:          filt_nxt = 10'b1110_0101_00;
         8'd9:          filt_nxt = 10'b1111_0101_00;
         8'd10:         filt_nxt = 10'b1111_1001_00;
         8'd11:         filt_nxt = 10'b1101_0001_00;
         [8'd12:8'd15]: filt_nxt = 10'b1111_1001_00;
         [8'd16:8'd17]: filt_nxt = 10'b1111_0101_00;
         [8'd18:8'd20]: filt_nxt = 10'b1100_0001_00;
         [8'd21:8'd24]: filt_nxt = 10'b0101_1100_00;
         [8'd25:8'd40]: filt_nxt = 10'b0011_0100_00;
         [8'd41:8'd45]: filt_nxt = 10'b0010_1000_00;
         [8'd46:8'd47]: filt_nxt = 10'b0111_0001_00;
         [8'd48:8'd51]: filt_nxt = 10'b0100_1100_00;
         [8'd52:8'd53]: filt_nxt = 10'b0110_0001_00;
         [8'd54:8'd56]: filt_nxt = 10'b0101_0110_00;
         [8'd57:8'd60]: filt_nxt = 10'b0010_0100_00;
         8'd61:         filt_nxt = 10'b0100_1010_00;
         [8'd62:8'd63]: filt_nxt = 10'b0011_1100_00;
         default:       filt_nxt = 10'b0010_1111_00;  // Same as divide by one
      endcase
   end

   always_ff @(posedge dclk) begin
      lock <= '{
         ref_dly:    lock_dly,
         fb_dly:     lock_dly,
         lock_cnt:   lock_cnt,
         sat_high:   10'd1001,  // Constant over the whole table
         unlock_cnt: 10'd1
      };
      filt <= filt_nxt;
   end

endmodule

/* rtl/mmcm_reconfig_top.sv */
`timescale 1ns/10ps

module mmcm_reconfig_top #(
   parameter int num_clkout = 7  // 6 for a PLL
) (
   input  logic                    dclk,
   input  logic                    rst,
   input  logic                    start,
   input  logic                    locked,
   input  mmcm_cfg_pkg::cnt_cfg_t  clkout [num_clkout],
   input  mmcm_cfg_pkg::cnt_cfg_t  clkfb,
   input  mmcm_cfg_pkg::div_cfg_t  div,
   output mmcm_drp_pkg::drp_req_t  drp_req,
   input  mmcm_drp_pkg::drp_rsp_t  drp_rsp,
   output logic                    rst_mmcm,
   output logic                    ready,
   output logic                    done
);

   mmcm_cfg_pkg::lock_cfg_t lock_cfg;
   mmcm_cfg_pkg::filt_cfg_t filt_cfg;
   mmcm_cfg_pkg::step_t     step;
   mmcm_drp_pkg::drp_addr_t img_addr;
   mmcm_drp_pkg::drp_data_t img_mask;
   mmcm_drp_pkg::drp_data_t img_data;

   mmcm_loop_table u_table (
      .dclk (dclk),
      .div  (div),
      .lock (lock_cfg),
      .filt (filt_cfg)
   );

   mmcm_reg_image #(.num_clkout(num_clkout)) u_image (
      .step   (step),
      .clkout (clkout),
      .clkfb  (clkfb),
      .div    (div),
      .lock   (lock_cfg),
      .filt   (filt_cfg),
      .addr   (img_addr),
      .mask   (img_mask),
      .data   (img_data)
   );

   mmcm_drp_rmw #(.num_clkout(num_clkout)) u_rmw (
      .dclk     (dclk),
      .rst      (rst),
      .start    (start),
      .locked   (locked),
      .step     (step),
      .addr     (img_addr),
      .mask     (img_mask),
      .data     (img_data),
      .req      (drp_req),
      .rsp      (drp_rsp),
      .rst_mmcm (rst_mmcm),
      .ready    (ready),
      .done     (done)
   );

endmodule

/* rtl/mmcm_reg_image.sv */
`timescale 1ns/10ps

module mmcm_reg_image #(
   parameter int num_clkout = 7
) (
   input  mmcm_cfg_pkg::step_t     step,
   input  mmcm_cfg_pkg::cnt_cfg_t  clkout [num_clkout],
   input  mmcm_cfg_pkg::cnt_cfg_t  clkfb,
   input  mmcm_cfg_pkg::div_cfg_t  div,
   input  mmcm_cfg_pkg::lock_cfg_t lock,
   input  mmcm_cfg_pkg::filt_cfg_t filt,
   output mmcm_drp_pkg::drp_addr_t addr,
   output mmcm_drp_pkg::drp_data_t mask,
   output mmcm_drp_pkg::drp_data_t data
);

   localparam int num_steps = 2 * num_clkout + 9;
   localparam int div_step  = 2 * num_clkout + 1;  // First step after the counters
   localparam int idx_w     = $clog2(mmcm_cfg_pkg::MAX_CLKOUT);

   logic [idx_w-1:0]    idx;
   mmcm_cfg_pkg::step_t rel;

   function automatic mmcm_drp_pkg::drp_data_t pack_reg1(mmcm_cfg_pkg::cnt_cfg_t c);
      return {c.phase_mux, 1'b0, c.high_time, c.low_time};
   endfunction

   // Fractional and fine phase bits stay zero
   function automatic mmcm_drp_pkg::drp_data_t pack_reg2(mmcm_cfg_pkg::cnt_cfg_t c);
      return {8'h00, c.edge_bit, c.no_count, c.delay_time};
   endfunction

   always_comb begin
      idx  = idx_w'((step - 1'b1) >> 1);
      rel  = step - mmcm_cfg_pkg::step_t'(div_step);
      addr = mmcm_drp_pkg::POWER_REG;
      mask = mmcm_drp_pkg::MASK_POWER;
      data = 16'hFFFF;

      if (step != '0 && step < div_step) begin
         addr = mmcm_drp_pkg::CLKOUT_REG1_ADDR[idx] + {6'd0, ~step[0]};
         if (step[0]) begin  // Odd steps hit the first register
            mask = mmcm_drp_pkg::MASK_CNT_REG1;
            data = pack_reg1(clkout[idx]);
         end else begin
            if (idx == '0)
               mask = mmcm_drp_pkg::MASK_CLK0_REG2;
            else if (idx >= 3'd5)
               mask = mmcm_drp_pkg::MASK_CLK56_REG2;
            else
               mask = mmcm_drp_pkg::MASK_CNT_REG2;
            data = pack_reg2(clkout[idx]);
         end
      end else if (step != '0) begin
         case (rel)
            5'd0: begin
               addr = mmcm_drp_pkg::DIVCLK_REG;
               mask = mmcm_drp_pkg::MASK_DIVCLK;
               data = {2'b00, div.edge_bit, div.no_count, div.high_time, div.low_time};
            end
            5'd1: begin
               addr = mmcm_drp_pkg::CLKFBOUT_REG1;
               mask = mmcm_drp_pkg::MASK_CNT_REG1;
               data = pack_reg1(clkfb);
            end
            5'd2: begin
               addr = mmcm_drp_pkg::CLKFBOUT_REG2;
               mask = mmcm_drp_pkg::MASK_CLK0_REG2;
               data = pack_reg2(clkfb);
            end
            5'd3: begin
               addr = mmcm_drp_pkg::LOCK_REG1;
               mask = mmcm_drp_pkg::MASK_LOCK1;
               data = {6'd0, lock.lock_cnt};
            end
            5'd4: begin
               addr = mmcm_drp_pkg::LOCK_REG2;
               mask = mmcm_drp_pkg::MASK_LOCK23;
               data = {1'b0, lock.fb_dly, lock.unlock_cnt};
            end
            5'd5: begin
               addr = mmcm_drp_pkg::LOCK_REG3;
               mask = mmcm_drp_pkg::MASK_LOCK23;
               data = {1'b0, lock.ref_dly, lock.sat_high};
            end
            5'd6: begin
               addr = mmcm_drp_pkg::FILT_REG1;
               mask = mmcm_drp_pkg::MASK_FILT1;
               data = {filt[9], 2'b00, filt[8:7], 2'b00, filt[6], 8'h00};
            end
            5'd7: begin
               addr = mmcm_drp_pkg::FILT_REG2;
               mask = mmcm_drp_pkg::MASK_FILT2;
               data = {filt[5], 2'b00, filt[4:3], 2'b00, filt[2:1], 2'b00, filt[0], 4'h0};
            end
            default: ;
         endcase
      end
   end

   // Sequencer must never walk past the last register
   step_in_range: assert final ($isunknown(step) || step < num_steps);

endmodule

/* sim/mmcm_drp_model.sv */
`timescale 1ns/10ps

module mmcm_drp_model (
   input  logic                   dclk,
   input  mmcm_drp_pkg::drp_req_t req,
   output mmcm_drp_pkg::drp_rsp_t rsp,
   input  logic                   rst_mmcm,
   output logic                   locked
);

   logic [15:0]             regs [128];
   logic [31:0]             lfsr;
   logic                    busy;
   logic                    in_reset;
   logic [1:0]              rdy_wait;
   logic [4:0]              lock_wait;
   mmcm_drp_pkg::drp_addr_t cur_addr;

   // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   initial begin
      lfsr      = 32'he5ab2cea;
      busy      = 1'b0;
      in_reset  = 1'b1;
      rdy_wait  = '0;
      lock_wait = '0;
      cur_addr  = '0;
      rsp       = '0;
      locked    = 1'b0;
      for (int a = 0; a < 128; a++)
         regs[a] = 16'(rand_bits(16));  // Power-up register contents
   end

   always @(posedge dclk) begin
      rsp.rdy <= 1'b0;
      if (req.en) begin
         busy     <= 1'b1;
         cur_addr <= req.addr;
         rdy_wait <= 2'(rand_bits(2));
         if (req.we)
            regs[req.addr] <= req.wdata;
      end else if (busy) begin
         if (rdy_wait == '0) begin
            busy      <= 1'b0;
            rsp.rdy   <= 1'b1;
            rsp.rdata <= regs[cur_addr];
         end else begin
            rdy_wait <= rdy_wait - 1'b1;
         end
      end

      // Lock returns some cycles after reset is released
      if (rst_mmcm !== 1'b0) begin
         locked   <= 1'b0;
         in_reset <= 1'b1;
      end else if (in_reset) begin
         in_reset  <= 1'b0;
         lock_wait <= 5'd3 + 5'(rand_bits(4));
      end else if (lock_wait != '0) begin
         lock_wait <= lock_wait - 1'b1;
      end else begin
         locked <= 1'b1;
      end
   end

endmodule

/* sim/tb_mmcm_reconfig.sv */
`timescale 1ns/10ps

module tb_mmcm_reconfig;

   localparam int num_clkout = 7;
   localparam int num_steps  = 2 * num_clkout + 9;
   localparam int num_runs   = 4;
   localparam int timeout_ns = num_runs * num_steps * 12 * 4 + 4000;

   logic                    dclk = 1'b0;
   logic                    rst;
   logic                    start;
   logic                    locked;
   mmcm_cfg_pkg::cnt_cfg_t  clkout [num_clkout];
   mmcm_cfg_pkg::cnt_cfg_t  clkfb;
   mmcm_cfg_pkg::div_cfg_t  div;
   mmcm_drp_pkg::drp_req_t  drp_req;
   mmcm_drp_pkg::drp_rsp_t  drp_rsp;
   logic                    rst_mmcm;
   logic                    ready;
   logic                    done;

   logic [31:0] lfsr = 32'he5ab2cea;
   logic        outstanding;
   logic        pend_we;
   logic        run_active;
   logic        rd_valid;
   logic [6:0]  pend_addr;
   logic [6:0]  rd_addr;
   logic [15:0] rd_data;
   int          wr_count;
   int          run_count;
   logic [6:0]  exp_addr;
   logic [15:0] exp_wdata;

   always #2 dclk = ~dclk;

   mmcm_reconfig_top #(.num_clkout(num_clkout)) dut0 (
      .dclk     (dclk),
      .rst      (rst),
      .start    (start),
      .locked   (locked),
      .clkout   (clkout),
      .clkfb    (clkfb),
      .div      (div),
      .drp_req  (drp_req),
      .drp_rsp  (drp_rsp),
      .rst_mmcm (rst_mmcm),
      .ready    (ready),
      .done     (done)
   );

   mmcm_drp_model u_model (
      .dclk     (dclk),
      .req      (drp_req),
      .rsp      (drp_rsp),
      .rst_mmcm (rst_mmcm),
      .locked   (locked)
   );

   // Fibonacci LFSR, taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
         lfsr = {lfsr[30:0], fb};
         v    = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [6:0] addr_of_step(input int k);
      logic [6:0] first [7];
      first = '{7'h08, 7'h0A, 7'h0C, 7'h0E, 7'h10, 7'h06, 7'h12};
      if (k >= 1 && k <= 2 * num_clkout)
         return first[3'((k - 1) / 2)] + 7'((k - 1) % 2);
      case (k)
         0:       return 7'h28;
         15:      return 7'h16;
         16:      return 7'h14;
         17:      return 7'h15;
         18:      return 7'h18;
         19:      return 7'h19;
         20:      return 7'h1A;
         21:      return 7'h4E;
         default: return 7'h4F;
      endcase
   endfunction

   function automatic logic [15:0] keep_mask(input int k);
      if (k >= 1 && k <= 2 * num_clkout) begin
         if (k % 2 == 1)
            return 16'h1000;
         if (k == 2)
            return 16'h8000;
         return k >= 12 ? 16'hC000 : 16'hFC00;  // CLKOUT5 and CLKOUT6 from step 12
      end
      case (k)
         0:       return 16'h0000;
         15:      return 16'hC000;
         16:      return 16'h1000;
         17:      return 16'h8000;
         18:      return 16'hFC00;
         19, 20:  return 16'h8000;
         21:      return 16'h66FF;
         default: return 16'h666F;
      endcase
   endfunction

   function automatic logic [15:0] field_word(input int k);
      mmcm_cfg_pkg::cnt_cfg_t c;
      int                     idx;
      logic [9:0]             f;
      c = clkfb;
      if (k >= 1 && k <= 2 * num_clkout)
         c = clkout[3'((k - 1) / 2)];
      idx = div.no_count ? 0 : div.high_time + div.low_time - 1;
      f   = idx == 0 ? 10'b0010111100 : 10'b0011110000;
      case (k)
         0:  return 16'hFFFF;
         15: return {2'b00, div.edge_bit, div.no_count, div.high_time, div.low_time};
         18: return idx == 0 ? 16'h03E8 : 16'h00FA;  // Lock count
         19: return idx == 0 ? 16'h1801 : 16'h7C01;
         20: return idx == 0 ? 16'h1BE9 : 16'h7FE9;
         21: return (16'(f[9]) << 15) | (16'(f[8:7]) << 11) | (16'(f[6]) << 8);
         22: return (16'(f[5]) << 15) | (16'(f[4:3]) << 11) | (16'(f[2:1]) << 7)
                    | (16'(f[0]) << 4);
         default: begin
            if ((k <= 2 * num_clkout && k % 2 == 1) || k == 16)
               return {c.phase_mux, 1'b0, c.high_time, c.low_time};
            return {8'h00, c.edge_bit, c.no_count, c.delay_time};
         end
      endcase
   endfunction

   always_comb begin
      exp_addr  = addr_of_step(wr_count);
      exp_wdata = (rd_data & keep_mask(wr_count)) | field_word(wr_count);
   end

   task automatic abort_run();
      $display("=== FAIL ===");
      $fatal(1, "Simulation stopped on error");
   endtask

   task automatic value_mismatch(input string name, input logic [15:0] expected,
                                 input logic [15:0] actual);
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
      abort_run();
   endtask

   task automatic protocol_error(input string what);
      $display("Error at %0t: %s", $time, what);
      abort_run();
   endtask

   // Even runs bypass the divider (index 0), odd runs divide by 64 (index 63)
   task automatic load_settings(input int run);
      for (int i = 0; i < num_clkout; i++)
         clkout[i] <= 23'(rand_bits(23));
      clkfb        <= 23'(rand_bits(23));
      div.edge_bit <= 1'(rand_bits(1));
      if (run % 2 == 1) begin
         div.high_time <= 6'd32;
         div.low_time  <= 6'd32;
         div.no_count  <= 1'b0;
      end else begin
         div.high_time <= run == 0 ? 6'd1 : 6'(rand_bits(6));
         div.low_time  <= run == 0 ? 6'd1 : 6'(rand_bits(6));
         div.no_count  <= 1'b1;
      end
   endtask

   always @(posedge dclk) begin
      if (rst) begin
         outstanding <= 1'b0;
         pend_we     <= 1'b0;
         run_active  <= 1'b0;
         rd_valid    <= 1'b0;
         wr_count    <= 0;
         run_count   <= 0;
      end else begin
         if (ready && start) begin
            run_active <= 1'b1;
            wr_count   <= 0;
         end
         if (done) begin
            run_active <= 1'b0;
            run_count  <= run_count + 1;
         end
         if (drp_req.en) begin
            outstanding <= 1'b1;
            pend_we     <= drp_req.we;
            pend_addr   <= drp_req.addr;
            if (drp_req.we) begin
               wr_count <= wr_count + 1;
               rd_valid <= 1'b0;
            end
         end else if (drp_rsp.rdy) begin
            outstanding <= 1'b0;
            if (!pend_we) begin
               rd_valid <= 1'b1;
               rd_addr  <= pend_addr;
               rd_data  <= drp_rsp.rdata;
            end
         end
      end
   end

   ready_after_lock: assert property (@(posedge dclk) disable iff (rst)
      $rose(ready) |-> $past(locked))
      else protocol_error("ready rose while the MMCM was not locked");
   start_taken: assert property (@(posedge dclk) disable iff (rst)
      ready && start |=> !ready && drp_req.en && !drp_req.we && rst_mmcm)
      else protocol_error("start was not followed by a read with the MMCM in reset");
   run_in_reset: assert property (@(posedge dclk) disable iff (rst)
      run_active |-> rst_mmcm && !ready)
      else protocol_error("rst_mmcm low or ready high during a run");
   en_legal: assert property (@(posedge dclk) disable iff (rst)
      drp_req.en |-> run_active && !outstanding)
      else protocol_error("DRP enable outside a run or with a transfer outstanding");
   addr_order: assert property (@(posedge dclk) disable iff (rst)
      drp_req.en |-> drp_req.addr == exp_addr)
      else value_mismatch("drp_req.addr", 16'($sampled(exp_addr)),
                          16'($sampled(drp_req.addr)));
   read_before_write: assert property (@(posedge dclk) disable iff (rst)
      drp_req.en && drp_req.we |-> rd_valid && rd_addr == drp_req.addr)
      else protocol_error("write without a read of the same address");
   write_data: assert property (@(posedge dclk) disable iff (rst)
      drp_req.en && drp_req.we |-> drp_req.wdata == exp_wdata)
      else value_mismatch("drp_req.wdata", $sampled(exp_wdata), $sampled(drp_req.wdata));
   done_after_last: assert property (@(posedge dclk) disable iff (rst)
      done |-> wr_count == num_steps && !outstanding && $past(drp_rsp.rdy))
      else protocol_error("done before the last write completed");
   last_write_done: assert property (@(posedge dclk) disable iff (rst)
      drp_rsp.rdy && pend_we && wr_count == num_steps |=> done)
      else protocol_error("no done after the last write");
   done_release: assert property (@(posedge dclk) disable iff (rst)
      done |=> !done && !rst_mmcm)
      else protocol_error("done not a single pulse followed by reset release");

   initial begin
      rst   = 1'b1;
      start = 1'b0;
      load_settings(0);
      repeat (2) @(posedge dclk);
      rst <= 1'b0;
      for (int r = 0; r < num_runs; r++) begin
         @(posedge dclk iff ready);
         start <= 1'b1;
         @(posedge dclk);
         start <= 1'b0;
         repeat (20) @(posedge dclk);
         start <= 1'b1;  // Busy, ignored
         @(posedge dclk);
         start <= 1'b0;
         @(posedge dclk iff done);
         if (r + 1 < num_runs)
            load_settings(r + 1);
      end
      repeat (4) @(posedge dclk);
      if (run_count == num_runs && wr_count == num_steps) begin
         $display("=== PASS ===");
         $finish;
      end else begin
         $display("Only %0d of %0d runs completed", run_count, num_runs);
         abort_run();
      end
   end

   initial begin
      #(timeout_ns);
      $display("Timeout: the runs did not finish within %0d ns", timeout_ns);
      abort_run();
   end

endmodule
